/* tb.f */
+incdir+hdl
hdl/mgmt_pkg.sv
hdl/hk_spi_slave.sv
hdl/host_port.sv
hdl/reg_arbiter.sv
hdl/hk_regs.sv
hdl/clock_ctrl.sv
hdl/mgmt_core_lite.sv
tb/mgmt_props.sv
tb/tb_mgmt_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass or fail from the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f tb.f --top-module tb_mgmt_core -Mdir "$BUILD_DIR" -o tb_mgmt_core; then
	echo "build failed"
	exit 1
fi

"$BUILD_DIR/tb_mgmt_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

/* tb/tb_mgmt_core.sv */
`timescale 1ns/1ps
`include "mgmt_defs.svh"

module tb_mgmt_core;

	logic clock;
	logic rst;
	logic sck;
	logic csb;
	logic sdi;
	logic host_stb;
	logic host_we;
	mgmt_pkg::mgmt_addr_t host_adr;
	mgmt_pkg::mgmt_data_t host_dat;
	mgmt_pkg::mgmt_data_t host_rdata;
	logic host_ack;
	logic [`MGMT_MASK_REV_W-1:0] mask_rev;
	logic sdo;
	logic sdo_outenb;
	logic jtag;
	logic jtag_outenb;
	mgmt_pkg::mgmt_data_t mgmt_out;
	logic irq;
	logic core_rstn;
	logic user_clk_en;
	int checks_run;
	int checks_failed;
	// Cycles from the strobe cycle to the acknowledge, last host access
	int ack_latency;

	mgmt_core_lite mgmt_core_lite_i (
		.clock_i(clock), .rst_i(rst),
		.sck_i(sck), .csb_i(csb), .sdi_i(sdi),
		.host_stb_i(host_stb), .host_we_i(host_we),
		.host_adr_i(host_adr), .host_dat_i(host_dat),
		.host_dat_o(host_rdata), .host_ack_o(host_ack),
		.mask_rev_i(mask_rev),
		.sdo_o(sdo), .sdo_outenb_o(sdo_outenb),
		.jtag_o(jtag), .jtag_outenb_o(jtag_outenb),
		.mgmt_out_o(mgmt_out), .irq_o(irq),
		.core_rstn_o(core_rstn), .user_clk_en_o(user_clk_en)
	);

	// 100 ns clock
	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks_run++;
		if (actual !== expected) begin
			checks_failed++;
			$display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic report_failure(input string what);
		checks_failed++;
		$display("%s (at %0t)", what, $time);
	endtask

	task automatic end_test(input string name, input int fails_before);
		$display("test %s finished with %0d errors", name, checks_failed - fails_before);
	endtask

	// One strobe, then wait at falling edges for the acknowledge
	task automatic host_access(input logic we, input mgmt_pkg::mgmt_addr_t adr,
			input mgmt_pkg::mgmt_data_t wdat, output mgmt_pkg::mgmt_data_t rdat);
		int waited;
		@(posedge clock);
		host_stb <= 1'b1;
		host_we <= we;
		host_adr <= adr;
		host_dat <= wdat;
		@(posedge clock);
		host_stb <= 1'b0;
		waited = 1;
		@(negedge clock);
		while (!host_ack && waited < 20) begin
			waited++;
			@(negedge clock);
		end
		if (!host_ack)
			report_failure("host acknowledge did not arrive within 20 cycles");
		ack_latency = waited;
		rdat = host_rdata;
	endtask

	task automatic host_write(input mgmt_pkg::mgmt_addr_t adr, input mgmt_pkg::mgmt_data_t d);
		mgmt_pkg::mgmt_data_t unused_rd;
		host_access(1'b1, adr, d, unused_rd);
	endtask

	task automatic host_read_check(input mgmt_pkg::mgmt_addr_t adr,
			input mgmt_pkg::mgmt_data_t expected, input string what);
		mgmt_pkg::mgmt_data_t rd;
		host_access(1'b0, adr, 8'h00, rd);
		check(rd, expected, $sformatf("%s at address %0h", what, adr));
	endtask

	// Mode 0 frame of command and data byte, SCK half period of 8 clocks
	task automatic spi_xfer(input logic [7:0] cmd, input logic [7:0] wdat,
			output logic [7:0] rdat);
		logic [15:0] frame;
		int i;
		frame = {cmd, wdat};
		rdat = 8'h00;
		@(posedge clock);
		csb <= 1'b0;
		for (i = 15; i >= 0; i--) begin
			sdi <= frame[i];
			repeat (7) @(posedge clock);
			// Sample SDO late in the low half, just ahead of the rising edge
			@(negedge clock);
			if (i < 8)
				rdat[i] = sdo;
			// Output enable is low only in the data byte of a read
			check(sdo_outenb, (i < 8 && !cmd[7]) ? 1'b0 : 1'b1,
				"sdo_outenb_o low only in a read data byte");
			@(posedge clock);
			sck <= 1'b1;
			repeat (8) @(posedge clock);
			sck <= 1'b0;
		end
		repeat (8) @(posedge clock);
		csb <= 1'b1;
		repeat (8) @(posedge clock);
	endtask

	// Find one enable pulse, then count cycles to the next
	task automatic measure_enable_gap(output int gap);
		int n;
		n = 0;
		@(negedge clock);
		while (!user_clk_en && n < 64) begin
			n++;
			@(negedge clock);
		end
		n = 1;
		@(negedge clock);
		while (!user_clk_en && n < 64) begin
			n++;
			@(negedge clock);
		end
		if (!user_clk_en)
			report_failure("user clock enable stopped pulsing");
		gap = n;
	endtask

	task automatic test_reset_defaults();
		int fails_before;
		int a;
		mgmt_pkg::mgmt_data_t expected;
		fails_before = checks_failed;
		repeat (7) @(posedge clock);
		// Output state while reset is still applied
		@(negedge clock);
		check(host_ack, 1'b0, "host_ack_o in reset");
		check(irq, 1'b0, "irq_o in reset");
		check(sdo_outenb, 1'b1, "sdo_outenb_o in reset");
		check(jtag_outenb, 1'b1, "jtag_outenb_o in reset");
		check(core_rstn, 1'b0, "core_rstn_o in reset");
		@(posedge clock);
		rst <= 1'b0;
		for (a = 0; a < 9; a++) begin
			// Mask revision low byte first, override resets to 3, the rest clear
			if (a < 4)
				expected = mask_rev[8*a +: 8];
			else if (a == `REG_OVERRIDE)
				expected = 8'h03;
			else
				expected = 8'h00;
			host_read_check(mgmt_pkg::mgmt_addr_t'(a), expected, "reset value");
			if (a == 0)
				check(ack_latency, 2, "uncontested host ack latency");
		end
		host_read_check(7'h5a, 8'h00, "unmapped read");
		check(core_rstn, 1'b1, "core_rstn_o released after reset");
		end_test("reset_defaults", fails_before);
	endtask

	task automatic test_coherence();
		int fails_before;
		mgmt_pkg::mgmt_data_t d;
		logic [7:0] rd;
		fails_before = checks_failed;
		d = mgmt_pkg::mgmt_data_t'($urandom);
		spi_xfer({1'b1, `REG_MGMT_OUT}, d, rd);
		host_read_check(`REG_MGMT_OUT, d, "SPI write seen by host");
		check(mgmt_out, d, "mgmt_out_o after SPI write");
		d = mgmt_pkg::mgmt_data_t'($urandom);
		host_write(`REG_MGMT_OUT, d);
		spi_xfer({1'b0, `REG_MGMT_OUT}, 8'h00, rd);
		check(rd, d, "host write seen over SPI");
		check(mgmt_out, d, "mgmt_out_o after host write");
		end_test("coherence", fails_before);
	endtask

	task automatic test_override();
		int fails_before;
		int v;
		logic [7:0] rd;
		fails_before = checks_failed;
		host_write(`REG_OVERRIDE, 8'h00);
		check(jtag_outenb, 1'b0, "jtag_outenb_o with override cleared");
		// Pins follow management output bits 1 and 0
		for (v = 0; v < 4; v++) begin
			host_write(`REG_MGMT_OUT, mgmt_pkg::mgmt_data_t'(v));
			check(sdo, v[1], "sdo_o from mgmt_out bit 1");
			check(jtag, v[0], "jtag_o from mgmt_out bit 0");
		end
		host_write(`REG_OVERRIDE, 8'h03);
		check(jtag, 1'b0, "jtag_o with override set");
		check(jtag_outenb, 1'b1, "jtag_outenb_o with override set");
		spi_xfer({1'b0, `REG_MASK_REV1}, 8'h00, rd);
		check(rd, mask_rev[15:8], "SPI read data on sdo_o");
		end_test("override", fails_before);
	endtask

	task automatic test_contention();
		int fails_before;
		int n;
		int ofs;
		int contended;
		mgmt_pkg::mgmt_data_t d;
		logic [7:0] spi_rd;
		fails_before = checks_failed;
		contended = 0;
		d = mgmt_pkg::mgmt_data_t'($urandom);
		host_write(`REG_MGMT_OUT, d);
		// Host traffic at three phase offsets, one of them meets the SPI read request
		for (ofs = 0; ofs < 3; ofs++) begin
			fork
				spi_xfer({1'b0, `REG_MGMT_OUT}, 8'h00, spi_rd);
				begin
					repeat (ofs) @(posedge clock);
					for (n = 0; n < 48; n++) begin
						host_read_check(mgmt_pkg::mgmt_addr_t'(n % 4),
							mask_rev[8*(n%4) +: 8], "host read during SPI");
						check(ack_latency <= 3, 1'b1, "host ack within 3 cycles");
						if (ack_latency == 3)
							contended++;
					end
				end
			join
			check(spi_rd, d, "SPI read under host traffic");
		end
		// SPI wins a tie after host service, so one host ack comes a cycle late
		check(contended > 0, 1'b1, "host access delayed by a competing SPI request");
		end_test("contention", fails_before);
	endtask

	task automatic test_clocking();
		int fails_before;
		int div;
		int gap;
		int n;
		fails_before = checks_failed;
		div = 2 + ($urandom % 6);
		host_write(`REG_CLK_DIV, mgmt_pkg::mgmt_data_t'(div));
		repeat (2) begin
			measure_enable_gap(gap);
			check(gap, div + 1, "user clock enable spacing");
		end
		host_write(`REG_CORE_RESET, 8'h01);
		repeat (6) begin
			check(core_rstn, 1'b0, "core_rstn_o while request set");
			check(user_clk_en, 1'b0, "user_clk_en_o while core in reset");
			@(negedge clock);
		end
		// Request bit drops on the acknowledge edge, then 4 more cycles low
		host_write(`REG_CORE_RESET, 8'h00);
		n = 0;
		while (!core_rstn && n < 20) begin
			n++;
			@(negedge clock);
		end
		if (!core_rstn)
			report_failure("core reset was never released");
		check(n, `CORE_RST_STRETCH, "core reset stretch after request cleared");
		end_test("clocking", fails_before);
	endtask

	task automatic test_interrupt();
		int fails_before;
		logic [7:0] rd;
		fails_before = checks_failed;
		spi_xfer({1'b1, `REG_IRQ}, 8'h01, rd);
		check(irq, 1'b1, "irq_o after SPI write");
		host_read_check(`REG_IRQ, 8'h01, "interrupt flag");
		host_write(`REG_IRQ, 8'h00);
		check(irq, 1'b0, "irq_o after host clear");
		end_test("interrupt", fails_before);
	endtask

	initial begin
		rst = 1'b1;
		sck = 1'b0;
		csb = 1'b1;
		sdi = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_dat = '0;
		checks_run = 0;
		checks_failed = 0;
		ack_latency = 0;
		void'($urandom(32'h8bc7));
		mask_rev = $urandom;
		test_reset_defaults();
		test_coherence();
		test_override();
		test_contention();
		test_clocking();
		test_interrupt();
		$display("summary: %0d checks run, %0d errors", checks_run, checks_failed);
		if (checks_failed == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tb/mgmt_props.sv */
`timescale 1ns/1ps

module mgmt_props (
	input logic clock_i,
	input logic rst_i,
	input logic spi_req_i,
	input logic host_req_i,
	input logic spi_done_i,
	input logic host_done_i
);

	// Source of the most recent done, seen from outside the arbiter
	mgmt_pkg::mgmt_src_e served_q;

	always_ff @(posedge clock_i) begin
		if (rst_i)
			served_q <= mgmt_pkg::SRC_HOST;
		else if (spi_done_i)
			served_q <= mgmt_pkg::SRC_SPI;
		else if (host_done_i)
			served_q <= mgmt_pkg::SRC_HOST;
	end

	// Shared read return serves one requester per cycle
	one_done: assert property (@(posedge clock_i) disable iff (rst_i)
		!(spi_done_i && host_done_i))
		else $error("spi and host done in the same cycle");

	// A requester holds req through its done cycle
	spi_done_req: assert property (@(posedge clock_i) disable iff (rst_i)
		spi_done_i |-> spi_req_i)
		else $error("spi done without a pending request");
	host_done_req: assert property (@(posedge clock_i) disable iff (rst_i)
		host_done_i |-> host_req_i)
		else $error("host done without a pending request");

	// host_ack_o is this done, one cycle wide
	ack_single: assert property (@(posedge clock_i) disable iff (rst_i)
		host_done_i |=> !host_done_i)
		else $error("host acknowledge high on two successive cycles");

	// Both waiting, so the next done goes to the one not served last
	rr_turn: assert property (@(posedge clock_i) disable iff (rst_i)
		(spi_req_i && !spi_done_i && host_req_i && !host_done_i) |=>
		((served_q == mgmt_pkg::SRC_HOST) ? spi_done_i : host_done_i))
		else $error("grant went to the requester served last");

endmodule

bind reg_arbiter mgmt_props mgmt_props_i (
	.clock_i(clock_i), .rst_i(rst_i),
	.spi_req_i(spi_req_i), .host_req_i(host_req_i),
	.spi_done_i(spi_done_o), .host_done_i(host_done_o)
);

/* hdl/mgmt_core_lite.sv */
`timescale 1ns/1ps
`include "mgmt_defs.svh"

module mgmt_core_lite (
	input  logic                        clock_i,
	input  logic                        rst_i,
	input  logic                        sck_i,
	input  logic                        csb_i,
	input  logic                        sdi_i,
	input  logic                        host_stb_i,
	input  logic                        host_we_i,
	input  mgmt_pkg::mgmt_addr_t        host_adr_i,
	input  mgmt_pkg::mgmt_data_t        host_dat_i,
	output mgmt_pkg::mgmt_data_t        host_dat_o,
	output logic                        host_ack_o,
	input  logic [`MGMT_MASK_REV_W-1:0] mask_rev_i,
	output logic                        sdo_o,
	output logic                        sdo_outenb_o,
	output logic                        jtag_o,
	output logic                        jtag_outenb_o,
	output mgmt_pkg::mgmt_data_t        mgmt_out_o,
	output logic                        irq_o,
	output logic                        core_rstn_o,
	output logic                        user_clk_en_o
);

	// SPI requester
	logic spi_req, spi_we, spi_done;
	mgmt_pkg::mgmt_addr_t spi_addr;
	mgmt_pkg::mgmt_data_t spi_wdata;
	logic sdo_pre;
	// Host requester
	logic host_req, host_we, host_done;
	mgmt_pkg::mgmt_addr_t host_addr;
	mgmt_pkg::mgmt_data_t host_wdata;
	mgmt_pkg::mgmt_data_t arb_rdata;
	// Register bus
	logic acc_en, acc_we;
	mgmt_pkg::mgmt_addr_t acc_addr;
	mgmt_pkg::mgmt_data_t acc_wdata, acc_rdata;
	// Clocking controls
	logic [`MGMT_CLKDIV_W-1:0] clk_div;
	logic core_reset_req;

	hk_spi_slave hk_spi_slave_i (
		.clock_i(clock_i), .rst_i(rst_i),
		.sck_i(sck_i), .csb_i(csb_i), .sdi_i(sdi_i),
		.sdo_o(sdo_pre), .sdo_outenb_o(sdo_outenb_o),
		.req_o(spi_req), .we_o(spi_we), .addr_o(spi_addr), .wdata_o(spi_wdata),
		.done_i(spi_done), .rdata_i(arb_rdata)
	);

	host_port host_port_i (
		.clock_i(clock_i), .rst_i(rst_i),
		.host_stb_i(host_stb_i), .host_we_i(host_we_i),
		.host_adr_i(host_adr_i), .host_dat_i(host_dat_i),
		.host_dat_o(host_dat_o), .host_ack_o(host_ack_o),
		.req_o(host_req), .we_o(host_we), .addr_o(host_addr), .wdata_o(host_wdata),
		.done_i(host_done), .rdata_i(arb_rdata)
	);

	reg_arbiter reg_arbiter_i (
		.clock_i(clock_i), .rst_i(rst_i),
		.spi_req_i(spi_req), .spi_we_i(spi_we),
		.spi_addr_i(spi_addr), .spi_wdata_i(spi_wdata), .spi_done_o(spi_done),
		.host_req_i(host_req), .host_we_i(host_we),
		.host_addr_i(host_addr), .host_wdata_i(host_wdata), .host_done_o(host_done),
		.rdata_o(arb_rdata),
		.acc_en_o(acc_en), .acc_we_o(acc_we),
		.acc_addr_o(acc_addr), .acc_wdata_o(acc_wdata), .acc_rdata_i(acc_rdata)
	);

	hk_regs hk_regs_i (
		.clock_i(clock_i), .rst_i(rst_i),
		.acc_en_i(acc_en), .acc_we_i(acc_we),
		.acc_addr_i(acc_addr), .acc_wdata_i(acc_wdata),
		.mask_rev_i(mask_rev_i), .sdo_pre_i(sdo_pre),
		.acc_rdata_o(acc_rdata), .clk_div_o(clk_div),
		.core_reset_req_o(core_reset_req), .mgmt_out_o(mgmt_out_o), .irq_o(irq_o),
		.sdo_o(sdo_o), .jtag_o(jtag_o), .jtag_outenb_o(jtag_outenb_o)
	);

	clock_ctrl clock_ctrl_i (
		.clock_i(clock_i), .rst_i(rst_i),
		.clk_div_i(clk_div), .core_reset_req_i(core_reset_req),
		.core_rstn_o(core_rstn_o), .user_clk_en_o(user_clk_en_o)
	);

endmodule

/* hdl/clock_ctrl.sv */
`timescale 1ns/1ps
`include "mgmt_defs.svh"

module clock_ctrl (
	input  logic                      clock_i,
	input  logic                      rst_i,
	input  logic [`MGMT_CLKDIV_W-1:0] clk_div_i,
	input  logic                      core_reset_req_i,
	output logic                      core_rstn_o,
	output logic                      user_clk_en_o
);

	localparam int STRETCH_W = $clog2(`CORE_RST_STRETCH + 1);

	logic [STRETCH_W-1:0] stretch_q;
	logic rstn_q;
	logic [`MGMT_CLKDIV_W-1:0] div_cnt_q;

	// Reload while any reset source is up, count down after release
	always_ff @(posedge clock_i) begin
		if (rst_i || core_reset_req_i) begin
			stretch_q <= STRETCH_W'(`CORE_RST_STRETCH - 1);
			rstn_q <= 1'b0;
		end else if (stretch_q != '0) begin
			stretch_q <= stretch_q - 1'b1;
		end else begin
			rstn_q <= 1'b1;
		end
	end

	// Request bit drops the core reset in the same cycle
	assign core_rstn_o = rstn_q & ~core_reset_req_i;

	// Divide counter wraps at the divider value
	always_ff @(posedge clock_i) begin
		if (rst_i || !core_rstn_o)
			div_cnt_q <= '0;
		else if (div_cnt_q >= clk_div_i)
			div_cnt_q <= '0;
		else
			div_cnt_q <= div_cnt_q + 1'b1;
	end

	// One pulse per divider plus one cycles
	assign user_clk_en_o = core_rstn_o & (div_cnt_q >= clk_div_i);

endmodule

/* hdl/hk_regs.sv */
`timescale 1ns/1ps
`include "mgmt_defs.svh"

module hk_regs (
	input  logic                         clock_i,
	input  logic                         rst_i,
	input  logic                         acc_en_i,
	input  logic                         acc_we_i,
	input  mgmt_pkg::mgmt_addr_t         acc_addr_i,
	input  mgmt_pkg::mgmt_data_t         acc_wdata_i,
	input  logic [`MGMT_MASK_REV_W-1:0]  mask_rev_i,
	input  logic                         sdo_pre_i,
	output mgmt_pkg::mgmt_data_t         acc_rdata_o,
	output logic [`MGMT_CLKDIV_W-1:0]    clk_div_o,
	output logic                         core_reset_req_o,
	output mgmt_pkg::mgmt_data_t         mgmt_out_o,
	output logic                         irq_o,
	output logic                         sdo_o,
	output logic                         jtag_o,
	output logic                         jtag_outenb_o
);

	logic [1:0] ovr_q;
	mgmt_pkg::mgmt_data_t rd_mux;

	// Writable registers
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			clk_div_o <= '0;
			ovr_q <= `OVERRIDE_RST;
			mgmt_out_o <= '0;
			core_reset_req_o <= 1'b0;
			irq_o <= 1'b0;
		end else if (acc_en_i && acc_we_i) begin
			case (acc_addr_i)
				`REG_CLK_DIV: clk_div_o <= acc_wdata_i[`MGMT_CLKDIV_W-1:0];
				`REG_OVERRIDE: ovr_q <= acc_wdata_i[1:0];
				`REG_MGMT_OUT: mgmt_out_o <= acc_wdata_i;
				`REG_CORE_RESET: core_reset_req_o <= acc_wdata_i[0];
				`REG_IRQ: irq_o <= acc_wdata_i[0];
				// Mask revision and unmapped space ignore writes
				default: ;
			endcase
		end
	end

	// Read decode, unmapped reads as zero
	always_comb begin
		case (acc_addr_i)
			`REG_MASK_REV0: rd_mux = mask_rev_i[7:0];
			`REG_MASK_REV1: rd_mux = mask_rev_i[15:8];
			`REG_MASK_REV2: rd_mux = mask_rev_i[23:16];
			`REG_MASK_REV3: rd_mux = mask_rev_i[31:24];
			`REG_CLK_DIV: rd_mux = mgmt_pkg::mgmt_data_t'(clk_div_o);
			`REG_OVERRIDE: rd_mux = mgmt_pkg::mgmt_data_t'(ovr_q);
			`REG_MGMT_OUT: rd_mux = mgmt_out_o;
			`REG_CORE_RESET: rd_mux = mgmt_pkg::mgmt_data_t'(core_reset_req_o);
			`REG_IRQ: rd_mux = mgmt_pkg::mgmt_data_t'(irq_o);
			default: rd_mux = '0;
		endcase
	end

	// Read data one cycle after the access
	always_ff @(posedge clock_i) begin
		if (acc_en_i)
			acc_rdata_o <= rd_mux;
	end

	// Cleared enable state hands the pin to the management output byte
	assign sdo_o = (ovr_q[0] == 1'b0) ? mgmt_out_o[1] : sdo_pre_i;
	// No JTAG source here, so pin idles low
	assign jtag_o = (ovr_q[1] == 1'b0) ? mgmt_out_o[0] : 1'b0;
	assign jtag_outenb_o = ovr_q[1];

endmodule

/* hdl/reg_arbiter.sv */
`timescale 1ns/1ps
`include "mgmt_defs.svh"

module reg_arbiter (
	input  logic                 clock_i,
	input  logic                 rst_i,
	input  logic                 spi_req_i,
	input  logic                 spi_we_i,
	input  mgmt_pkg::mgmt_addr_t spi_addr_i,
	input  mgmt_pkg::mgmt_data_t spi_wdata_i,
	output logic                 spi_done_o,
	input  logic                 host_req_i,
	input  logic                 host_we_i,
	input  mgmt_pkg::mgmt_addr_t host_addr_i,
	input  mgmt_pkg::mgmt_data_t host_wdata_i,
	output logic                 host_done_o,
	output mgmt_pkg::mgmt_data_t rdata_o,
	output logic                 acc_en_o,
	output logic                 acc_we_o,
	output mgmt_pkg::mgmt_addr_t acc_addr_o,
	output mgmt_pkg::mgmt_data_t acc_wdata_o,
	input  mgmt_pkg::mgmt_data_t acc_rdata_i
);

	mgmt_pkg::mgmt_src_e last_q;
	mgmt_pkg::mgmt_src_e gnt;
	logic spi_elig;
	logic host_elig;

	// A requester seeing done this cycle still holds req, so skip it
	assign spi_elig = spi_req_i & ~spi_done_o;
	assign host_elig = host_req_i & ~host_done_o;

	always_comb begin
		if (spi_elig && host_elig)
			gnt = (last_q == mgmt_pkg::SRC_SPI) ? mgmt_pkg::SRC_HOST : mgmt_pkg::SRC_SPI;
		else if (spi_elig)
			gnt = mgmt_pkg::SRC_SPI;
		else
			gnt = mgmt_pkg::SRC_HOST;
	end

	assign acc_en_o = spi_elig | host_elig;
	// Bus mux follows the grant
	assign acc_we_o = (gnt == mgmt_pkg::SRC_SPI) ? spi_we_i : host_we_i;
	assign acc_addr_o = (gnt == mgmt_pkg::SRC_SPI) ? spi_addr_i : host_addr_i;
	assign acc_wdata_o = (gnt == mgmt_pkg::SRC_SPI) ? spi_wdata_i : host_wdata_i;

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			last_q <= mgmt_pkg::SRC_HOST;
			spi_done_o <= 1'b0;
			host_done_o <= 1'b0;
		end else begin
			// done one cycle after grant, matching registered read data
			spi_done_o <= acc_en_o && (gnt == mgmt_pkg::SRC_SPI);
			host_done_o <= acc_en_o && (gnt == mgmt_pkg::SRC_HOST);
			if (acc_en_o)
				last_q <= gnt;
		end
	end

	// Shared return path, qualified by each done
	assign rdata_o = acc_rdata_i;

endmodule

/* hdl/host_port.sv */
`timescale 1ns/1ps
`include "mgmt_defs.svh"

module host_port (
	input  logic                 clock_i,
	input  logic                 rst_i,
	input  logic                 host_stb_i,
	input  logic                 host_we_i,
	input  mgmt_pkg::mgmt_addr_t host_adr_i,
	input  mgmt_pkg::mgmt_data_t host_dat_i,
	output mgmt_pkg::mgmt_data_t host_dat_o,
	output logic                 host_ack_o,
	output logic                 req_o,
	output logic                 we_o,
	output mgmt_pkg::mgmt_addr_t addr_o,
	output mgmt_pkg::mgmt_data_t wdata_o,
	input  logic                 done_i,
	input  mgmt_pkg::mgmt_data_t rdata_i
);

	// Strobe turns into a level request held until done
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			req_o <= 1'b0;
		end else if (host_stb_i) begin
			req_o <= 1'b1;
		end else if (done_i) begin
			req_o <= 1'b0;
		end
	end

	// Access fields captured with the strobe
	always_ff @(posedge clock_i) begin
		if (host_stb_i) begin
			we_o <= host_we_i;
			addr_o <= host_adr_i;
			wdata_o <= host_dat_i;
		end
	end

	// done is already a single-cycle pulse from the arbiter
	assign host_ack_o = done_i;
	// Data valid together with ack
	assign host_dat_o = rdata_i;

endmodule

/* hdl/hk_spi_slave.sv */
`timescale 1ns/1ps
`include "mgmt_defs.svh"

module hk_spi_slave (
	input  logic                 clock_i,
	input  logic                 rst_i,
	input  logic                 sck_i,
	input  logic                 csb_i,
	input  logic                 sdi_i,
	output logic                 sdo_o,
	output logic                 sdo_outenb_o,
	output logic                 req_o,
	output logic                 we_o,
	output mgmt_pkg::mgmt_addr_t addr_o,
	output mgmt_pkg::mgmt_data_t wdata_o,
	input  logic                 done_i,
	input  mgmt_pkg::mgmt_data_t rdata_i
);

	localparam int SYNC_N = `SPI_SYNC_STAGES;

	// Command byte, data byte, then wait for CSB high
	typedef enum logic [1:0] {
		ST_CMD  = 2'd0,
		ST_DATA = 2'd1,
		ST_END  = 2'd2
	} spi_st_e;

	logic [SYNC_N-1:0] sck_sync;
	logic [SYNC_N-1:0] csb_sync;
	logic [SYNC_N-1:0] sdi_sync;
	logic sck_d;
	logic sck_s;
	logic csb_s;
	logic sdi_s;
	logic sck_rise;
	logic sck_fall;
	spi_st_e state_q;
	logic [2:0] bit_cnt_q;
	logic [6:0] shift_in_q;
	mgmt_pkg::mgmt_data_t shift_out_q;
	logic sdo_q;

	// Pins are asynchronous to clock_i
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			sck_sync <= '0;
			csb_sync <= '1;
			sdi_sync <= '0;
			sck_d <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[SYNC_N-2:0], sck_i};
			csb_sync <= {csb_sync[SYNC_N-2:0], csb_i};
			sdi_sync <= {sdi_sync[SYNC_N-2:0], sdi_i};
			sck_d <= sck_s;
		end
	end

	assign sck_s = sck_sync[SYNC_N-1];
	assign csb_s = csb_sync[SYNC_N-1];
	assign sdi_s = sdi_sync[SYNC_N-1];
	// One-cycle SCK edge strobes
	assign sck_rise = sck_s & ~sck_d;
	assign sck_fall = ~sck_s & sck_d;

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state_q <= ST_CMD;
			bit_cnt_q <= 3'd0;
			req_o <= 1'b0;
			we_o <= 1'b0;
			sdo_q <= 1'b0;
		end else begin
			// Request stays up until the arbiter answers
			if (done_i)
				req_o <= 1'b0;
			if (csb_s) begin
				// Deselect aborts whatever byte is in flight
				state_q <= ST_CMD;
				bit_cnt_q <= 3'd0;
			end else if (sck_rise) begin
				bit_cnt_q <= bit_cnt_q + 3'd1;
				if (bit_cnt_q == 3'd7) begin
					case (state_q)
						ST_CMD: begin
							// Bit 7 of the command selects write
							we_o <= shift_in_q[6];
							state_q <= ST_DATA;
							// Read goes out now so data is ready for byte two
							if (!shift_in_q[6])
								req_o <= 1'b1;
						end
						ST_DATA: begin
							state_q <= ST_END;
							if (we_o)
								req_o <= 1'b1;
						end
						default: begin
							state_q <= ST_END;
						end
					endcase
				end
			end else if (sck_fall && state_q == ST_DATA && !we_o) begin
				// Mode 0, SDO moves after falling SCK
				sdo_q <= shift_out_q[7];
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (sck_rise && !csb_s)
			shift_in_q <= {shift_in_q[5:0], sdi_s};
		if (sck_rise && !csb_s && bit_cnt_q == 3'd7 && state_q == ST_CMD)
			addr_o <= {shift_in_q[5:0], sdi_s};
		if (sck_rise && !csb_s && bit_cnt_q == 3'd7 && state_q == ST_DATA)
			wdata_o <= {shift_in_q, sdi_s};
		// Read data lands well before the first falling edge of byte two
		if (done_i && !we_o)
			shift_out_q <= rdata_i;
		else if (sck_fall && !csb_s && state_q == ST_DATA)
			shift_out_q <= {shift_out_q[6:0], 1'b0};
	end

	assign sdo_o = sdo_q;
	// Drive SDO only for the data byte of a read
	assign sdo_outenb_o = ~(state_q == ST_DATA && !we_o);

endmodule

/* hdl/mgmt_pkg.sv */
`include "mgmt_defs.svh"

package mgmt_pkg;

	// Register address on the shared bus
	typedef logic [`MGMT_ADDR_W-1:0] mgmt_addr_t;

	// One register byte
	typedef logic [`MGMT_DATA_W-1:0] mgmt_data_t;

	// Which master owns an access
	typedef enum logic {
		SRC_SPI  = 1'b0,
		SRC_HOST = 1'b1
	} mgmt_src_e;

endpackage

/* hdl/mgmt_defs.svh */
`ifndef MGMT_DEFS_SVH
`define MGMT_DEFS_SVH

// Register bus widths
`define MGMT_ADDR_W 7
`define MGMT_DATA_W 8
// Divider field and mask revision vector
`define MGMT_CLKDIV_W 5
`define MGMT_MASK_REV_W 32

// Housekeeping register map
// Mask revision, low byte first
`define REG_MASK_REV0 7'h00
`define REG_MASK_REV1 7'h01
`define REG_MASK_REV2 7'h02
`define REG_MASK_REV3 7'h03
`define REG_CLK_DIV 7'h04
// Bit 0 SDO enable state, bit 1 JTAG enable state, 0 means override
`define REG_OVERRIDE 7'h05
`define REG_MGMT_OUT 7'h06
`define REG_CORE_RESET 7'h07
`define REG_IRQ 7'h08
`define OVERRIDE_RST 2'b11

// Core reset hold after release, in clock cycles
`define CORE_RST_STRETCH 4
// SPI pin synchronizer depth
`define SPI_SYNC_STAGES 2

`endif
